// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csr
LINT_TOP  ?= csr_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== csr_arch_pkg.sv ====
package csr_arch_pkg;

    localparam int XLEN   = 32;
    localparam int ADDR_W = 12;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_e;

    // exception and interrupt codes share the value 11
    typedef logic [4:0] exc_code_e;

    localparam exc_code_e EXC_II      = 5'd2;
    localparam exc_code_e EXC_ECALL_U = 5'd8;
    localparam exc_code_e EXC_ECALL_M = 5'd11;
    localparam exc_code_e IRQ_MSI     = 5'd3;
    localparam exc_code_e IRQ_MTI     = 5'd7;
    localparam exc_code_e IRQ_MEI     = 5'd11;

    localparam logic [ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [ADDR_W-1:0] CSR_MISA     = 12'h301;
    localparam logic [ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [ADDR_W-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [ADDR_W-1:0] CSR_MIP      = 12'h344;
    localparam logic [ADDR_W-1:0] CSR_MCYCLE   = 12'hB00;
    localparam logic [ADDR_W-1:0] CSR_MHARTID  = 12'hF14;

    // mie, mpie and mpp
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_1888;
    localparam logic [XLEN-1:0] MIE_MASK     = 32'h0000_0888;
    localparam logic [XLEN-1:0] MIP_MASK     = 32'h0000_0888;
    localparam logic [XLEN-1:0] MTVEC_MASK   = 32'hFFFF_FFFD;
    localparam logic [XLEN-1:0] EPC_MASK     = 32'hFFFF_FFFC;

    // rv32, I and U extensions
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_0100;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

endpackage

// ==== csr_decode.sv ====
module csr_decode
    import csr_arch_pkg::*;
    import csr_op_pkg::*;
(
    input  logic              valid_i,
    input  logic [2:0]        funct3_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [XLEN-1:0]   src_i,
    input  logic [XLEN-1:0]   imm_i,
    input  priv_mode_e        mode_i,
    output csr_op_e           op_o,
    output csr_sel_e          sel_o,
    output logic [XLEN-1:0]   operand_o,
    output logic              write_o,
    output logic              illegal_o
);
    logic hit;
    logic priv_ok;
    logic read_only;
    logic wants_write;

    always_comb begin
        case (funct3_i[1:0])
            2'b01:   op_o = OP_RW;
            2'b10:   op_o = OP_RS;
            2'b11:   op_o = OP_RC;
            default: op_o = OP_NONE;
        endcase
        if (!valid_i) begin
            op_o = OP_NONE;
        end
    end

    always_comb begin
        hit = 1'b1;
        case (addr_i)
            CSR_MSTATUS:  sel_o = SEL_MSTATUS;
            CSR_MISA:     sel_o = SEL_MISA;
            CSR_MIE:      sel_o = SEL_MIE;
            CSR_MTVEC:    sel_o = SEL_MTVEC;
            CSR_MSCRATCH: sel_o = SEL_MSCRATCH;
            CSR_MEPC:     sel_o = SEL_MEPC;
            CSR_MCAUSE:   sel_o = SEL_MCAUSE;
            CSR_MTVAL:    sel_o = SEL_MTVAL;
            CSR_MIP:      sel_o = SEL_MIP;
            CSR_MCYCLE:   sel_o = SEL_MCYCLE;
            CSR_MHARTID:  sel_o = SEL_MHARTID;
            default: begin
                sel_o = SEL_MSTATUS;
                hit   = 1'b0;
            end
        endcase
    end

    // uimm form takes the zero-extended immediate
    assign operand_o = funct3_i[2] ? imm_i : src_i;

    // set/clear with zero source is a pure read
    assign wants_write = (op_o == OP_RW) ||
                         (((op_o == OP_RS) || (op_o == OP_RC)) && (operand_o != '0));

    assign priv_ok   = mode_i >= addr_i[9:8];
    // misa is fixed here even though its address is writable space
    assign read_only = (&addr_i[11:10]) || (sel_o == SEL_MISA);

    assign illegal_o = valid_i &&
                       ((op_o == OP_NONE) || !hit || !priv_ok || (wants_write && read_only));
    assign write_o   = valid_i && !illegal_o && wants_write;

    // a write never reaches read-only space or a more privileged level
    always_comb begin
        if (write_o) begin
            assert (!(&addr_i[11:10]) && (mode_i >= addr_i[9:8]) && (op_o != OP_NONE));
        end
    end

endmodule

// ==== csr_execute.sv ====
module csr_execute
    import csr_arch_pkg::*;
    import csr_op_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  csr_op_e         op_i,
    input  csr_sel_e        sel_i,
    input  logic [XLEN-1:0] operand_i,
    input  logic            write_i,
    input  logic            flush_i,
    input  logic [XLEN-1:0] mstatus_i,
    input  logic [XLEN-1:0] misa_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mscratch_i,
    input  logic [XLEN-1:0] mepc_i,
    input  logic [XLEN-1:0] mcause_i,
    input  logic [XLEN-1:0] mtval_i,
    input  logic [XLEN-1:0] mip_i,
    input  logic [XLEN-1:0] mcycle_i,
    input  logic [XLEN-1:0] mhartid_i,
    output logic [XLEN-1:0] rdata_o,
    output logic            wr_en_o,
    output csr_sel_e        wr_sel_o,
    output logic [XLEN-1:0] wr_data_o
);
    logic [XLEN-1:0] new_val;
    logic            s1_valid;
    logic            s2_valid;
    csr_sel_e        s1_sel;
    csr_sel_e        s2_sel;
    logic [XLEN-1:0] s1_data;
    logic [XLEN-1:0] s2_data;

    always_comb begin
        case (sel_i)
            SEL_MSTATUS:  rdata_o = mstatus_i;
            SEL_MISA:     rdata_o = misa_i;
            SEL_MIE:      rdata_o = mie_i;
            SEL_MTVEC:    rdata_o = mtvec_i;
            SEL_MSCRATCH: rdata_o = mscratch_i;
            SEL_MEPC:     rdata_o = mepc_i;
            SEL_MCAUSE:   rdata_o = mcause_i;
            SEL_MTVAL:    rdata_o = mtval_i;
            SEL_MIP:      rdata_o = mip_i;
            SEL_MCYCLE:   rdata_o = mcycle_i;
            SEL_MHARTID:  rdata_o = mhartid_i;
            default:      rdata_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_RS:   new_val = rdata_o | operand_i;
            OP_RC:   new_val = rdata_o & ~operand_i;
            default: new_val = operand_i;
        endcase
    end

    // flush kills the issue cycle and both stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= write_i & ~flush_i;
            s2_valid <= s1_valid & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_sel  <= sel_i;
        s1_data <= new_val;
        s2_sel  <= s1_sel;
        s2_data <= s1_data;
    end

    assign wr_en_o   = s2_valid & ~flush_i;
    assign wr_sel_o  = s2_sel;
    assign wr_data_o = s2_data;

    // a flush in this cycle or the two before leaves nothing to write
    a_no_write_after_flush: assert property (
        @(posedge clk) disable iff (rst)
        wr_en_o |-> !flush_i && !$past(flush_i) && !$past(flush_i, 2)
    );

endmodule

// ==== csr_irq.sv ====
module csr_irq
    import csr_arch_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            msip_i,
    input  logic            mtip_i,
    input  logic            meip_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic            mstatus_mie_i,
    input  priv_mode_e      mode_i,
    output logic [XLEN-1:0] mip_o,
    output logic            irq_o,
    output exc_code_e       irq_cause_o
);
    // {meip, mtip, msip}
    logic [2:0] req_s1;
    logic [2:0] req_s2;
    logic [2:0] pend;
    logic       global_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_s1 <= '0;
            req_s2 <= '0;
        end else begin
            req_s1 <= {meip_i, mtip_i, msip_i};
            req_s2 <= req_s1;
        end
    end

    always_comb begin
        mip_o     = '0;
        mip_o[3]  = req_s2[0];
        mip_o[7]  = req_s2[1];
        mip_o[11] = req_s2[2];
    end

    assign pend      = {mie_i[11] & mip_o[11], mie_i[7] & mip_o[7], mie_i[3] & mip_o[3]};
    // user mode always takes machine interrupts
    assign global_en = (mode_i == PRIV_U) || mstatus_mie_i;
    assign irq_o     = (|pend) && global_en;

    assign irq_cause_o = pend[2] ? IRQ_MEI :
                         pend[1] ? IRQ_MTI :
                         pend[0] ? IRQ_MSI : exc_code_e'(5'd0);

    // the cause names a request line that was high two edges earlier
    a_irq_cause: assert property (
        @(posedge clk) disable iff (rst)
        irq_o |-> ((irq_cause_o == IRQ_MEI) && $past(meip_i, 2)) ||
                  ((irq_cause_o == IRQ_MTI) && $past(mtip_i, 2)) ||
                  ((irq_cause_o == IRQ_MSI) && $past(msip_i, 2))
    );

endmodule

// ==== csr_op_pkg.sv ====
package csr_op_pkg;

    // encoded like funct3 bits 1:0
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_RW   = 3'd1,
        OP_RS   = 3'd2,
        OP_RC   = 3'd3
    } csr_op_e;

    typedef enum logic [3:0] {
        SEL_MSTATUS,
        SEL_MISA,
        SEL_MIE,
        SEL_MTVEC,
        SEL_MSCRATCH,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MTVAL,
        SEL_MIP,
        SEL_MCYCLE,
        SEL_MHARTID
    } csr_sel_e;

endpackage

// ==== csr_regs.sv ====
module csr_regs
    import csr_arch_pkg::*;
    import csr_op_pkg::*;
#(
    parameter logic [XLEN-1:0] HART_ID = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_en_i,
    input  csr_sel_e        wr_sel_i,
    input  logic [XLEN-1:0] wr_data_i,
    input  logic            trap_take_i,
    input  logic            ret_take_i,
    input  exc_code_e       cause_i,
    input  logic            is_irq_i,
    input  logic [XLEN-1:0] epc_i,
    input  logic [XLEN-1:0] tval_i,
    input  priv_mode_e      mode_i,
    input  logic [XLEN-1:0] mip_i,
    output logic [XLEN-1:0] mstatus_o,
    output logic [XLEN-1:0] misa_o,
    output logic [XLEN-1:0] mie_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mscratch_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o,
    output logic [XLEN-1:0] mtval_o,
    output logic [XLEN-1:0] mip_o,
    output logic [XLEN-1:0] mcycle_o,
    output logic [XLEN-1:0] mhartid_o
);
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus_o  <= '0;
            mie_o      <= '0;
            mtvec_o    <= '0;
            mscratch_o <= '0;
            mepc_o     <= '0;
            mcause_o   <= '0;
            mtval_o    <= '0;
            mcycle_o   <= '0;
        end else begin
            mcycle_o <= mcycle_o + 1'b1;
            if (wr_en_i) begin
                case (wr_sel_i)
                    SEL_MSTATUS:  mstatus_o  <= wr_data_i & MSTATUS_MASK;
                    SEL_MIE:      mie_o      <= wr_data_i & MIE_MASK;
                    SEL_MTVEC:    mtvec_o    <= wr_data_i & MTVEC_MASK;
                    SEL_MSCRATCH: mscratch_o <= wr_data_i;
                    SEL_MEPC:     mepc_o     <= wr_data_i & EPC_MASK;
                    SEL_MCAUSE:   mcause_o   <= wr_data_i;
                    SEL_MTVAL:    mtval_o    <= wr_data_i;
                    SEL_MCYCLE:   mcycle_o   <= wr_data_i;
                    // misa, mip and mhartid ignore writes
                    default: ;
                endcase
            end
            // trap entry overrides a write landing on the same edge
            if (trap_take_i) begin
                mepc_o   <= epc_i & EPC_MASK;
                mcause_o <= {is_irq_i, {(XLEN-6){1'b0}}, cause_i};
                mtval_o  <= is_irq_i ? '0 : tval_i;
                mstatus_o[MSTATUS_MPIE]        <= mstatus_o[MSTATUS_MIE];
                mstatus_o[MSTATUS_MIE]         <= 1'b0;
                mstatus_o[MSTATUS_MPP_LO +: 2] <= mode_i;
            end else if (ret_take_i) begin
                mstatus_o[MSTATUS_MIE]         <= mstatus_o[MSTATUS_MPIE];
                mstatus_o[MSTATUS_MPIE]        <= 1'b1;
                mstatus_o[MSTATUS_MPP_LO +: 2] <= PRIV_U;
            end
        end
    end

    // pending bits come straight from the synchronizers
    assign mip_o     = mip_i & MIP_MASK;
    assign misa_o    = MISA_VALUE;
    assign mhartid_o = HART_ID;

endmodule

// ==== csr_top.sv ====
module csr_top
    import csr_arch_pkg::*;
    import csr_op_pkg::*;
#(
    parameter logic [XLEN-1:0] HART_ID = 32'h0000_0001
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_i,
    input  logic [2:0]        funct3_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [XLEN-1:0]   src_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic              flush_i,
    input  logic              trap_i,
    input  logic              ecall_i,
    input  logic              mret_i,
    input  exc_code_e         cause_i,
    input  logic [XLEN-1:0]   epc_i,
    input  logic [XLEN-1:0]   tval_i,
    input  logic              msip_i,
    input  logic              mtip_i,
    input  logic              meip_i,
    output logic [XLEN-1:0]   rdata_o,
    output logic              illegal_o,
    output logic [XLEN-1:0]   target_pc_o,
    output priv_mode_e        mode_o,
    output logic              irq_o,
    output exc_code_e         irq_cause_o
);
    csr_op_e         op;
    csr_sel_e        sel;
    logic [XLEN-1:0] operand;
    logic            write;
    logic            wr_en;
    csr_sel_e        wr_sel;
    logic [XLEN-1:0] wr_data;
    logic            trap_take;
    logic            ret_take;
    exc_code_e       trap_cause;
    logic            is_irq;
    logic [XLEN-1:0] mip_req;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] misa;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] mhartid;

    csr_decode u_decode (
        .valid_i(valid_i), .funct3_i(funct3_i), .addr_i(addr_i), .src_i(src_i),
        .imm_i(imm_i), .mode_i(mode_o), .op_o(op), .sel_o(sel),
        .operand_o(operand), .write_o(write), .illegal_o(illegal_o)
    );

    csr_execute u_execute (
        .clk(clk), .rst(rst), .op_i(op), .sel_i(sel), .operand_i(operand),
        .write_i(write), .flush_i(flush_i), .mstatus_i(mstatus), .misa_i(misa),
        .mie_i(mie), .mtvec_i(mtvec), .mscratch_i(mscratch), .mepc_i(mepc),
        .mcause_i(mcause), .mtval_i(mtval), .mip_i(mip), .mcycle_i(mcycle),
        .mhartid_i(mhartid), .rdata_o(rdata_o), .wr_en_o(wr_en),
        .wr_sel_o(wr_sel), .wr_data_o(wr_data)
    );

    csr_regs #(.HART_ID(HART_ID)) u_regs (
        .clk(clk), .rst(rst), .wr_en_i(wr_en), .wr_sel_i(wr_sel), .wr_data_i(wr_data),
        .trap_take_i(trap_take), .ret_take_i(ret_take), .cause_i(trap_cause),
        .is_irq_i(is_irq), .epc_i(epc_i), .tval_i(tval_i), .mode_i(mode_o),
        .mip_i(mip_req), .mstatus_o(mstatus), .misa_o(misa), .mie_o(mie),
        .mtvec_o(mtvec), .mscratch_o(mscratch), .mepc_o(mepc), .mcause_o(mcause),
        .mtval_o(mtval), .mip_o(mip), .mcycle_o(mcycle), .mhartid_o(mhartid)
    );

    csr_trap u_trap (
        .clk(clk), .rst(rst), .trap_i(trap_i), .ecall_i(ecall_i), .mret_i(mret_i),
        .irq_i(irq_o), .cause_i(cause_i), .irq_cause_i(irq_cause_o),
        .mstatus_i(mstatus), .mtvec_i(mtvec), .mepc_i(mepc), .mode_o(mode_o),
        .trap_take_o(trap_take), .ret_take_o(ret_take), .cause_o(trap_cause),
        .is_irq_o(is_irq), .target_pc_o(target_pc_o)
    );

    csr_irq u_irq (
        .clk(clk), .rst(rst), .msip_i(msip_i), .mtip_i(mtip_i), .meip_i(meip_i),
        .mie_i(mie), .mstatus_mie_i(mstatus[MSTATUS_MIE]), .mode_i(mode_o),
        .mip_o(mip_req), .irq_o(irq_o), .irq_cause_o(irq_cause_o)
    );

endmodule

// ==== csr_trap.sv ====
module csr_trap
    import csr_arch_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            trap_i,
    input  logic            ecall_i,
    input  logic            mret_i,
    input  logic            irq_i,
    input  exc_code_e       cause_i,
    input  exc_code_e       irq_cause_i,
    input  logic [XLEN-1:0] mstatus_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    output priv_mode_e      mode_o,
    output logic            trap_take_o,
    output logic            ret_take_o,
    output exc_code_e       cause_o,
    output logic            is_irq_o,
    output logic [XLEN-1:0] target_pc_o
);
    logic            mret_bad;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] vec_pc;

    // mret from user mode becomes an illegal-instruction trap
    assign mret_bad    = mret_i && (mode_o == PRIV_U);
    assign trap_take_o = trap_i | ecall_i | mret_bad;
    assign ret_take_o  = mret_i & ~mret_bad;
    assign is_irq_o    = trap_i & irq_i;

    always_comb begin
        if (ecall_i) begin
            cause_o = (mode_o == PRIV_U) ? EXC_ECALL_U : EXC_ECALL_M;
        end else if (mret_bad) begin
            cause_o = EXC_II;
        end else if (is_irq_o) begin
            cause_o = irq_cause_i;
        end else begin
            cause_o = cause_i;
        end
    end

    assign base   = {mtvec_i[XLEN-1:2], 2'b00};
    assign vec_pc = base + {{(XLEN-7){1'b0}}, cause_o, 2'b00};

    assign target_pc_o = ret_take_o                 ? mepc_i :
                         (is_irq_o && mtvec_i[0])   ? vec_pc : base;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_o <= PRIV_M;
        end else if (trap_take_o) begin
            mode_o <= PRIV_M;
        end else if (ret_take_o) begin
            // unsupported mpp encodings fall back to machine mode
            mode_o <= (mstatus_i[MSTATUS_MPP_LO +: 2] == PRIV_U) ? PRIV_U : PRIV_M;
        end
    end

endmodule

// ==== flist.f ====
+incdir+.
csr_arch_pkg.sv
csr_op_pkg.sv
csr_decode.sv
csr_execute.sv
csr_regs.sv
csr_trap.sv
csr_irq.sv
csr_top.sv
tb_csr.sv

// ==== tb_csr_tasks.svh ====
// right-shift galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] galois_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

task automatic rand_word(output logic [XLEN-1:0] word);
    for (int i = 0; i < XLEN; i++) begin
        lfsr_state = galois_step(lfsr_state);
        word[i] = lfsr_state[0];
    end
endtask

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
endtask

task automatic check_data(input string what, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
endtask

task automatic check_cause(input string what, input exc_code_e exp, input exc_code_e act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
endtask

task automatic check_mode(input string what, input priv_mode_e exp, input priv_mode_e act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
endtask

task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
endtask

task automatic end_test();
    tests++;
    if (errors == errors_at_start) begin
        $display("[%0t] %s: ok", $time, test_name);
    end else begin
        $display("[%0t] %s: %0d errors", $time, test_name, errors - errors_at_start);
    end
endtask

// drives one issue cycle and samples the old value and verdict mid-cycle
task automatic csr_access(input logic [2:0] f3, input logic [ADDR_W-1:0] a,
                          input logic [XLEN-1:0] value, output logic [XLEN-1:0] old,
                          output logic bad);
    valid  = 1'b1;
    funct3 = f3;
    addr   = a;
    src    = f3[2] ? '0 : value;
    imm    = f3[2] ? value : '0;
    #2;
    old = rdata;
    bad = illegal;
    next_cycle();
    valid = 1'b0;
endtask

task automatic read_csr(input logic [ADDR_W-1:0] a, output logic [XLEN-1:0] value);
    logic bad;
    csr_access(F_RS, a, '0, value, bad);
    check_bit("read legal", 1'b0, bad);
endtask

// returns once the write is visible
task automatic write_csr(input logic [2:0] f3, input logic [ADDR_W-1:0] a,
                         input logic [XLEN-1:0] value);
    logic [XLEN-1:0] old;
    logic            bad;
    csr_access(f3, a, value, old, bad);
    check_bit("write legal", 1'b0, bad);
    wait_cycles(2);
endtask

task automatic pulse_event(input logic t, input logic e, input logic m,
                           input logic [XLEN-1:0] pc, output logic [XLEN-1:0] target);
    trap  = t;
    ecall = e;
    mret  = m;
    epc   = pc;
    #2;
    target = target_pc;
    next_cycle();
    trap  = 1'b0;
    ecall = 1'b0;
    mret  = 1'b0;
endtask

task automatic wait_irq(input int limit, output exc_code_e seen_cause);
    logic seen;
    seen = 1'b0;
    seen_cause = 5'd0;
    for (int i = 0; i < limit; i++) begin
        #2;
        seen = irq;
        seen_cause = irq_cause;
        next_cycle();
        if (seen) begin
            break;
        end
    end
    if (!seen) begin
        errors++;
        $display("%s: no interrupt was raised within %0d cycles", test_name, limit);
    end
endtask

task automatic test_rw_scratch();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] exp;
    logic            bad;
    start_test("rw_scratch");
    rand_word(a);
    rand_word(b);
    rand_word(c);
    csr_access(F_RW, CSR_MSCRATCH, a, old, bad);
    check_bit("rw legal", 1'b0, bad);
    check_data("rw old", '0, old);
    wait_cycles(2);
    csr_access(F_RS, CSR_MSCRATCH, b, old, bad);
    check_data("rs old", a, old);
    wait_cycles(2);
    csr_access(F_RC, CSR_MSCRATCH, c, old, bad);
    check_data("rc old", a | b, old);
    wait_cycles(2);
    exp = (a | b) & ~c;
    read_csr(CSR_MSCRATCH, old);
    check_data("rc result", exp, old);
    csr_access(F_RWI, CSR_MSCRATCH, 32'h0000_0015, old, bad);
    check_data("rwi old", exp, old);
    wait_cycles(2);
    read_csr(CSR_MSCRATCH, old);
    check_data("rwi result", 32'h0000_0015, old);
    end_test();
endtask

task automatic test_warl();
    logic [XLEN-1:0] v;
    logic            bad;
    start_test("warl");
    // mstatus keeps mie, mpie and mpp only
    write_csr(F_RW, CSR_MSTATUS, '1);
    read_csr(CSR_MSTATUS, v);
    check_data("mstatus mask", 32'h0000_1888, v);
    write_csr(F_RW, CSR_MSTATUS, '0);
    write_csr(F_RW, CSR_MTVEC, '1);
    read_csr(CSR_MTVEC, v);
    check_data("mtvec mask", 32'hFFFF_FFFD, v);
    write_csr(F_RW, CSR_MEPC, '1);
    read_csr(CSR_MEPC, v);
    check_data("mepc mask", 32'hFFFF_FFFC, v);
    read_csr(CSR_MISA, v);
    check_data("misa value", MISA_VALUE, v);
    csr_access(F_RW, CSR_MISA, 32'h1234_5678, v, bad);
    check_bit("misa write illegal", 1'b1, bad);
    wait_cycles(2);
    read_csr(CSR_MISA, v);
    check_data("misa unchanged", MISA_VALUE, v);
    read_csr(CSR_MHARTID, v);
    check_data("mhartid", TB_HART_ID, v);
    csr_access(F_RW, CSR_MHARTID, '0, v, bad);
    check_bit("mhartid write illegal", 1'b1, bad);
    wait_cycles(2);
    read_csr(CSR_MHARTID, v);
    check_data("mhartid unchanged", TB_HART_ID, v);
    csr_access(F_RS, 12'h7C0, '0, v, bad);
    check_bit("unknown address illegal", 1'b1, bad);
    end_test();
endtask

task automatic test_flush();
    logic [XLEN-1:0] n;
    logic [XLEN-1:0] v;
    logic            bad;
    start_test("flush");
    write_csr(F_RW, CSR_MSCRATCH, 32'h1111_2222);
    rand_word(n);
    csr_access(F_RW, CSR_MSCRATCH, n, v, bad);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    wait_cycles(1);
    read_csr(CSR_MSCRATCH, v);
    check_data("flushed write", 32'h1111_2222, v);
    rand_word(n);
    csr_access(F_RW, CSR_MSCRATCH, n, v, bad);
    wait_cycles(2);
    // too late to cancel
    flush = 1'b1;
    read_csr(CSR_MSCRATCH, v);
    flush = 1'b0;
    check_data("late flush", n, v);
    end_test();
endtask

task automatic test_trap_return();
    logic [XLEN-1:0] tgt;
    logic [XLEN-1:0] v;
    logic            bad;
    start_test("trap_return");
    write_csr(F_RW, CSR_MTVEC, 32'h0000_1000);
    write_csr(F_RW, CSR_MSTATUS, 32'h0000_0008);
    pulse_event(1'b0, 1'b1, 1'b0, 32'h0000_2344, tgt);
    check_data("ecall target", 32'h0000_1000, tgt);
    check_mode("mode after ecall", PRIV_M, mode);
    read_csr(CSR_MCAUSE, v);
    check_cause("ecall from m", 5'd11, v[4:0]);
    read_csr(CSR_MEPC, v);
    check_data("mepc", 32'h0000_2344, v);
    read_csr(CSR_MSTATUS, v);
    check_data("mstatus on entry", 32'h0000_1880, v);
    // mpp to user before returning
    write_csr(F_RC, CSR_MSTATUS, 32'h0000_1800);
    pulse_event(1'b0, 1'b0, 1'b1, '0, tgt);
    check_data("mret target", 32'h0000_2344, tgt);
    check_mode("mode after mret", PRIV_U, mode);
    csr_access(F_RS, CSR_MSCRATCH, '0, v, bad);
    check_bit("m access from u", 1'b1, bad);
    pulse_event(1'b0, 1'b1, 1'b0, 32'h0000_2400, tgt);
    check_data("u ecall target", 32'h0000_1000, tgt);
    check_mode("mode after u ecall", PRIV_M, mode);
    read_csr(CSR_MCAUSE, v);
    check_cause("ecall from u", 5'd8, v[4:0]);
    read_csr(CSR_MSTATUS, v);
    check_data("mstatus after u ecall", 32'h0000_0080, v);
    end_test();
endtask

task automatic test_interrupts();
    logic [XLEN-1:0] tgt;
    logic [XLEN-1:0] v;
    exc_code_e       c;
    start_test("interrupts");
    write_csr(F_RW, CSR_MIE, 32'h0000_0888);
    write_csr(F_RS, CSR_MSTATUS, 32'h0000_0008);
    mtip = 1'b1;
    meip = 1'b1;
    wait_irq(8, c);
    check_cause("irq priority", 5'd11, c);
    read_csr(CSR_MIP, v);
    check_data("mip", 32'h0000_0880, v);
    write_csr(F_RC, CSR_MSTATUS, 32'h0000_0008);
    #2;
    check_bit("irq masked", 1'b0, irq);
    next_cycle();
    // vectored mode
    write_csr(F_RW, CSR_MTVEC, 32'h0000_1001);
    write_csr(F_RS, CSR_MSTATUS, 32'h0000_0008);
    pulse_event(1'b1, 1'b0, 1'b0, 32'h0000_3000, tgt);
    check_data("vectored target", 32'h0000_102C, tgt);
    check_mode("mode after irq", PRIV_M, mode);
    mtip = 1'b0;
    meip = 1'b0;
    read_csr(CSR_MCAUSE, v);
    check_data("irq mcause", 32'h8000_000B, v);
    end_test();
endtask

task automatic test_mcycle();
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
    logic            bad;
    start_test("mcycle");
    read_csr(CSR_MCYCLE, v1);
    wait_cycles(9);
    read_csr(CSR_MCYCLE, v2);
    check_data("elapsed", 32'd10, v2 - v1);
    csr_access(F_RW, CSR_MCYCLE, 32'h1000_0000, v2, bad);
    check_data("mcycle old", v1 + 32'd11, v2);
    wait_cycles(4);
    read_csr(CSR_MCYCLE, v2);
    check_data("count after write", 32'h1000_0002, v2);
    end_test();
endtask

// ==== tb_csr.sv ====
module tb_csr
    import csr_arch_pkg::*;
();
    localparam int              CLK_PERIOD = 8;
    localparam logic [XLEN-1:0] TB_HART_ID = 32'h0000_0003;
    localparam logic [31:0]     LFSR_SEED  = 32'he496;
    // six tests need about 150 cycles together
    localparam int              MAX_CYCLES = 2000;

    // funct3 encodings of the zicsr instructions
    localparam logic [2:0] F_RW  = 3'b001;
    localparam logic [2:0] F_RS  = 3'b010;
    localparam logic [2:0] F_RC  = 3'b011;
    localparam logic [2:0] F_RWI = 3'b101;

    logic              clk;
    logic              rst;
    logic              valid;
    logic [2:0]        funct3;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   src;
    logic [XLEN-1:0]   imm;
    logic              flush;
    logic              trap;
    logic              ecall;
    logic              mret;
    exc_code_e         cause;
    logic [XLEN-1:0]   epc;
    logic [XLEN-1:0]   tval;
    logic              msip;
    logic              mtip;
    logic              meip;
    logic [XLEN-1:0]   rdata;
    logic              illegal;
    logic [XLEN-1:0]   target_pc;
    priv_mode_e        mode;
    logic              irq;
    exc_code_e         irq_cause;

    logic [31:0] lfsr_state;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    int          errors_at_start;
    string       test_name;

    csr_top #(.HART_ID(TB_HART_ID)) dut (
        .clk(clk), .rst(rst), .valid_i(valid), .funct3_i(funct3), .addr_i(addr),
        .src_i(src), .imm_i(imm), .flush_i(flush), .trap_i(trap), .ecall_i(ecall),
        .mret_i(mret), .cause_i(cause), .epc_i(epc), .tval_i(tval), .msip_i(msip),
        .mtip_i(mtip), .meip_i(meip), .rdata_o(rdata), .illegal_o(illegal),
        .target_pc_o(target_pc), .mode_o(mode), .irq_o(irq), .irq_cause_o(irq_cause)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    `include "tb_csr_tasks.svh"

    initial begin
        lfsr_state = LFSR_SEED;
        rst    = 1'b1;
        valid  = 1'b0;
        funct3 = 3'b000;
        addr   = '0;
        src    = '0;
        imm    = '0;
        flush  = 1'b0;
        trap   = 1'b0;
        ecall  = 1'b0;
        mret   = 1'b0;
        cause  = 5'd0;
        epc    = '0;
        tval   = '0;
        msip   = 1'b0;
        mtip   = 1'b0;
        meip   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        test_rw_scratch();
        test_warl();
        test_flush();
        test_trap_return();
        test_interrupts();
        test_mcycle();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
